//--- Bender.yml
package:
  name: ahb_matrix

sources:
  - src/ahbMatrixPkg.sv
  - src/ahbMasterPort.sv
  - src/ahbSlavePort.sv
  - src/ahbMatrix.sv
  - target: test
    files:
      - verif/ahbMemSlave.sv
      - verif/ahbMatrixChecker.sv
      - verif/ahbMatrix_properties.sv
      - verif/ahbMatrixTb.sv

//--- src/ahbMasterPort.sv
// AHB matrix master port
`timescale 1ns/1ps
`default_nettype none

module ahbMasterPort (
  input  logic                                                HCLK,
  input  logic                                                reset,

  // Host side, one AHB-Lite master drives this
  input  ahbMatrixPkg::prio_t                                 hostPriority,
  input  ahbMatrixPkg::ahbReq_t                               hostReq,
  input  logic                                                hostReady,
  output ahbMatrixPkg::ahbRsp_t                               hostRsp,

  // Toward the slave ports
  output ahbMatrixPkg::ahbReq_t                               portReq,
  output ahbMatrixPkg::prio_t                                 portPriority,
  output ahbMatrixPkg::slaveMask_t                            portSel,
  output logic                                                canSwitch,
  input  ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numSlaves-1:0] slaveRsp,
  input  ahbMatrixPkg::slaveMask_t                            granted
);

  ahbMatrixPkg::masterState_e state;
  ahbMatrixPkg::masterState_e stateNext;
  ahbMatrixPkg::ahbReq_t      heldReq;
  ahbMatrixPkg::ahbReq_t      curReq;
  ahbMatrixPkg::ahbRsp_t      dataRsp;
  ahbMatrixPkg::slaveMask_t   hit;
  ahbMatrixPkg::slaveMask_t   slaveReadyVec;
  ahbMatrixPkg::slaveMask_t   dataSlave;
  ahbMatrixPkg::slaveMask_t   dataSlaveNext;
  logic                       mapped;
  logic                       isXfer;
  logic                       request;
  logic                       openState;
  logic                       passOk;
  logic                       targetOk;

  ////////////////////
  // Address decode
  ////////////////////

  // A stalled transfer replays from the holding register
  assign curReq = (state == ahbMatrixPkg::portWait) ? heldReq : hostReq;

  always_comb begin
    for (int s = 0; s < ahbMatrixPkg::numSlaves; s++) begin
      hit[s] = (curReq.addr & ahbMatrixPkg::slaveMask[s]) == ahbMatrixPkg::slaveBase[s];
      slaveReadyVec[s] = slaveRsp[s].ready;
    end
  end

  assign mapped = |hit;
  assign isXfer = (curReq.trans == ahbMatrixPkg::transNonseq) ||
                  (curReq.trans == ahbMatrixPkg::transSeq);

  // Request stays up while the host waits, independent of HREADY
  assign request = curReq.sel && (curReq.trans != ahbMatrixPkg::transIdle) &&
                   (state != ahbMatrixPkg::portErr1);
  assign portSel = request ? hit : '0;

  // Idle and the last error cycle both sample a new address phase
  assign openState = (state == ahbMatrixPkg::portIdle) || (state == ahbMatrixPkg::portErr2);
  assign passOk    = (state == ahbMatrixPkg::portWait) || (openState && hostReady);

  // Target slave is ours and takes the address this cycle
  assign targetOk = |(hit & granted & slaveReadyVec);

  // Mid-burst beats keep the slave port locked to us
  assign canSwitch = !((curReq.trans == ahbMatrixPkg::transSeq) ||
                       (curReq.trans == ahbMatrixPkg::transBusy));

  assign portPriority = hostPriority;

  // Address phase out, write data always from the live data phase
  always_comb begin
    portReq       = curReq;
    portReq.wdata = hostReq.wdata;
    portReq.sel   = curReq.sel && passOk;
    if (!portReq.sel) begin
      portReq.trans = ahbMatrixPkg::transIdle;
    end
  end

  ////////////////////
  // Port FSM
  ////////////////////

  always_comb begin
    stateNext     = state;
    dataSlaveNext = dataSlave;
    case (state)
      ahbMatrixPkg::portWait: begin
        // Held address leaves once the slave port grants it
        if (targetOk) begin
          stateNext     = ahbMatrixPkg::portIdle;
          dataSlaveNext = hit;
        end
      end
      ahbMatrixPkg::portErr1: stateNext = ahbMatrixPkg::portErr2;
      default: begin
        stateNext = ahbMatrixPkg::portIdle;
        if (hostReady) begin
          dataSlaveNext = '0;
          if (request && isXfer && !mapped) begin
            stateNext = ahbMatrixPkg::portErr1;
          end else if (request && isXfer && !targetOk) begin
            stateNext = ahbMatrixPkg::portWait;
          end else if (request && isXfer) begin
            dataSlaveNext = hit;
          end
        end
      end
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (reset) begin
      state     <= ahbMatrixPkg::portIdle;
      dataSlave <= '0;
    end else begin
      state     <= stateNext;
      dataSlave <= dataSlaveNext;
    end
  end

  // Snapshot of every sampled address phase
  always_ff @(posedge HCLK) begin
    if (openState && hostReady) begin
      heldReq <= hostReq;
    end
  end

  ////////////////////
  // Response select
  ////////////////////

  // No data phase in flight means zero-wait OKAY
  always_comb begin
    dataRsp.rdata = '0;
    dataRsp.ready = 1'b1;
    dataRsp.resp  = 1'b0;
    for (int s = 0; s < ahbMatrixPkg::numSlaves; s++) begin
      if (dataSlave[s]) begin
        dataRsp = slaveRsp[s];
      end
    end
  end

  always_comb begin
    hostRsp = dataRsp;
    case (state)
      ahbMatrixPkg::portWait: begin
        hostRsp.ready = 1'b0;
        hostRsp.resp  = 1'b0;
      end
      // Two-cycle ERROR for unmapped addresses
      ahbMatrixPkg::portErr1: begin
        hostRsp.ready = 1'b0;
        hostRsp.resp  = 1'b1;
      end
      ahbMatrixPkg::portErr2: begin
        hostRsp.ready = 1'b1;
        hostRsp.resp  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/ahbMatrix.sv
// AHB-Lite bus matrix top
`timescale 1ns/1ps
`default_nettype none

module ahbMatrix (
  input  logic                                                 HCLK,
  input  logic                                                 reset,

  // Master side, AHB-Lite masters connect here
  input  ahbMatrixPkg::prio_t [ahbMatrixPkg::numMasters-1:0]   masterPriority,
  input  ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numMasters-1:0] masterReq,
  input  ahbMatrixPkg::masterMask_t                            masterReady,
  output ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numMasters-1:0] masterRsp,

  // Slave side, AHB-Lite slaves connect here
  output ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numSlaves-1:0]  slaveReq,
  output ahbMatrixPkg::slaveMask_t                             slaveReady,
  input  ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numSlaves-1:0]  slaveRsp
);

  // Indexed by master
  ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numMasters-1:0]    fromMstReq;
  ahbMatrixPkg::prio_t [ahbMatrixPkg::numMasters-1:0]      fromMstPriority;
  ahbMatrixPkg::slaveMask_t [ahbMatrixPkg::numMasters-1:0] fromMstSel;
  ahbMatrixPkg::masterMask_t                               fromMstCanSwitch;
  ahbMatrixPkg::slaveMask_t [ahbMatrixPkg::numMasters-1:0] toMstGrant;

  // Indexed by slave
  ahbMatrixPkg::masterMask_t [ahbMatrixPkg::numSlaves-1:0] toSlvSel;
  ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numSlaves-1:0]     fromSlvRsp;
  ahbMatrixPkg::masterMask_t [ahbMatrixPkg::numSlaves-1:0] fromSlvGrant;

  genvar m;
  genvar s;

  ////////////////////
  // Master ports
  ////////////////////

  for (m = 0; m < ahbMatrixPkg::numMasters; m++) begin : genMasterPorts
    ahbMasterPort masterPort (
      .HCLK        (HCLK),
      .reset       (reset),
      .hostPriority(masterPriority[m]),
      .hostReq     (masterReq[m]),
      .hostReady   (masterReady[m]),
      .hostRsp     (masterRsp[m]),
      .portReq     (fromMstReq[m]),
      .portPriority(fromMstPriority[m]),
      .portSel     (fromMstSel[m]),
      .canSwitch   (fromMstCanSwitch[m]),
      .slaveRsp    (fromSlvRsp),
      .granted     (toMstGrant[m])
    );
  end

  ////////////////////
  // Crossbar transpose
  ////////////////////

  // Request bits go per slave, grant bits come back per master
  for (s = 0; s < ahbMatrixPkg::numSlaves; s++) begin : genSlaveWires
    for (m = 0; m < ahbMatrixPkg::numMasters; m++) begin : genMasterWires
      assign toSlvSel[s][m]   = fromMstSel[m][s];
      assign toMstGrant[m][s] = fromSlvGrant[s][m];
    end
  end

  ////////////////////
  // Slave ports
  ////////////////////

  for (s = 0; s < ahbMatrixPkg::numSlaves; s++) begin : genSlavePorts
    ahbSlavePort slavePort (
      .HCLK         (HCLK),
      .reset        (reset),
      .hostReq      (fromMstReq),
      .hostSel      (toSlvSel[s]),
      .hostPriority (fromMstPriority),
      .hostCanSwitch(fromMstCanSwitch),
      .hostRsp      (fromSlvRsp[s]),
      .grant        (fromSlvGrant[s]),
      .slaveReq     (slaveReq[s]),
      .slaveReady   (slaveReady[s]),
      .slaveRsp     (slaveRsp[s])
    );
  end

endmodule

`default_nettype wire

//--- src/ahbMatrixPkg.sv
// AHB bus matrix definitions
`default_nettype none

package ahbMatrixPkg;

  ////////////////////
  // Sizes
  ////////////////////

  localparam int numMasters = 3;
  localparam int numSlaves  = 2;
  localparam int addrWidth  = 32;
  localparam int dataWidth  = 32;
  localparam int prioWidth  = 2;

  // Plain vectors with a meaning
  typedef logic [addrWidth-1:0]  addr_t;
  typedef logic [dataWidth-1:0]  data_t;
  // Higher value wins arbitration
  typedef logic [prioWidth-1:0]  prio_t;
  typedef logic [1:0]            trans_t;
  typedef logic [numMasters-1:0] masterMask_t;
  typedef logic [numSlaves-1:0]  slaveMask_t;

  // HTRANS encodings
  localparam trans_t transIdle   = 2'b00;
  localparam trans_t transBusy   = 2'b01;
  localparam trans_t transNonseq = 2'b10;
  localparam trans_t transSeq    = 2'b11;

  ////////////////////
  // Address map
  ////////////////////

  // One 4 KiB window per slave, index 0 in the low word
  localparam addr_t [numSlaves-1:0] slaveBase = {32'h0001_0000, 32'h0000_0000};
  localparam addr_t [numSlaves-1:0] slaveMask = {32'hFFFF_F000, 32'hFFFF_F000};

  // Address phase plus write data of one transfer
  typedef struct packed {
    logic       sel;
    addr_t      addr;
    logic       write;
    logic [2:0] size;
    logic [2:0] burst;
    trans_t     trans;
    data_t      wdata;
  } ahbReq_t;

  // Data phase answer, resp high is ERROR
  typedef struct packed {
    data_t rdata;
    logic  ready;
    logic  resp;
  } ahbRsp_t;

  // Master port FSM
  typedef enum logic [1:0] {portIdle, portWait, portErr1, portErr2} masterState_e;

endpackage

`default_nettype wire

//--- src/ahbSlavePort.sv
// AHB matrix slave port
`timescale 1ns/1ps
`default_nettype none

module ahbSlavePort (
  input  logic                                                 HCLK,
  input  logic                                                 reset,

  ////////////////////
  // From master ports
  ////////////////////

  // Address phases of all masters
  input  ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numMasters-1:0] hostReq,
  // One bit per master that targets this slave
  input  ahbMatrixPkg::masterMask_t                            hostSel,
  input  ahbMatrixPkg::prio_t [ahbMatrixPkg::numMasters-1:0]   hostPriority,
  input  ahbMatrixPkg::masterMask_t                            hostCanSwitch,
  output ahbMatrixPkg::ahbRsp_t                                hostRsp,
  output ahbMatrixPkg::masterMask_t                            grant,

  ////////////////////
  // To the slave
  ////////////////////

  output ahbMatrixPkg::ahbReq_t                                slaveReq,
  output logic                                                 slaveReady,
  input  ahbMatrixPkg::ahbRsp_t                                slaveRsp
);

  // Address-phase owner
  ahbMatrixPkg::masterMask_t owner;
  // Data-phase owner, selects HWDATA
  ahbMatrixPkg::masterMask_t dataOwner;
  ahbMatrixPkg::masterMask_t pick;
  ahbMatrixPkg::prio_t       bestPrio;
  ahbMatrixPkg::ahbReq_t     addrReq;
  ahbMatrixPkg::data_t       dataWdata;
  logic                      ownerSel;
  logic                      ownerCanSwitch;
  logic                      switchOk;
  logic                      selOut;

  ////////////////////
  // Arbitration
  ////////////////////

  // Highest priority among requesters
  // Strict compare keeps ties on the lowest index
  always_comb begin
    pick     = '0;
    bestPrio = '0;
    for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
      if (hostSel[m] && ((pick == '0) || (hostPriority[m] > bestPrio))) begin
        pick     = '0;
        pick[m]  = 1'b1;
        bestPrio = hostPriority[m];
      end
    end
  end

  // Owner that left for another slave no longer blocks switching
  assign ownerSel       = |(owner & hostSel);
  assign ownerCanSwitch = |(owner & hostCanSwitch);

  // Only between transfers, never inside a burst
  assign switchOk = slaveRsp.ready && (!ownerSel || ownerCanSwitch);

  // New owner is visible in the same cycle
  assign grant = switchOk ? pick : owner;

  always_ff @(posedge HCLK) begin
    if (reset) begin
      owner <= '0;
    end else begin
      owner <= grant;
    end
  end

  ////////////////////
  // Address phase mux
  ////////////////////

  always_comb begin
    addrReq = '0;
    for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
      if (grant[m]) begin
        addrReq = hostReq[m];
      end
    end
  end

  // Granted master must also be aiming at this slave
  assign selOut = addrReq.sel && |(grant & hostSel);

  // Write data follows the data-phase owner
  always_comb begin
    dataWdata = '0;
    for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
      if (dataOwner[m]) begin
        dataWdata = hostReq[m].wdata;
      end
    end
  end

  always_comb begin
    slaveReq       = addrReq;
    slaveReq.sel   = selOut;
    slaveReq.wdata = dataWdata;
    // Deselected slave sees IDLE
    if (!selOut) begin
      slaveReq.trans = ahbMatrixPkg::transIdle;
    end
  end

  ////////////////////
  // Data phase
  ////////////////////

  // Owner changes only when the slave finishes its data phase
  // BUSY and IDLE leave no data phase behind
  always_ff @(posedge HCLK) begin
    if (reset) begin
      dataOwner <= '0;
    end else if (slaveRsp.ready) begin
      if (selOut && ((slaveReq.trans == ahbMatrixPkg::transNonseq) ||
                     (slaveReq.trans == ahbMatrixPkg::transSeq))) begin
        dataOwner <= grant;
      end else begin
        dataOwner <= '0;
      end
    end
  end

  // Single slave per port, so its own HREADYOUT is its HREADY
  assign slaveReady = slaveRsp.ready;

  // Every master port sees the answer, each picks its own slave
  assign hostRsp = slaveRsp;

endmodule

`default_nettype wire

//--- verif/ahbMatrixChecker.sv
// AHB matrix response checker
`timescale 1ns/1ps
`default_nettype none

module ahbMatrixChecker (
  input logic                                                 HCLK,
  input logic                                                 reset,
  input ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numMasters-1:0] masterReq,
  input ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numMasters-1:0] masterRsp,
  input ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numSlaves-1:0]  slaveReq,
  input ahbMatrixPkg::slaveMask_t                             slaveReady,
  input ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numSlaves-1:0]  slaveRsp
);

  // Expected outcome of one beat
  typedef struct packed {
    logic                write;
    logic                resp;
    ahbMatrixPkg::data_t data;
  } expBeat_t;

  expBeat_t                  expQ [ahbMatrixPkg::numMasters][$];
  ahbMatrixPkg::addr_t       orderQ[$];
  ahbMatrixPkg::masterMask_t pending;
  int                        burstLeft [ahbMatrixPkg::numSlaves];
  ahbMatrixPkg::addr_t       nextAddr [ahbMatrixPkg::numSlaves];
  int                        errorCount = 0;
  int                        checkedCount = 0;

  task automatic expectBeat(input int m, input logic write, input ahbMatrixPkg::data_t data,
                            input logic resp);
    expBeat_t b;
    b.write = write;
    b.resp  = resp;
    b.data  = data;
    expQ[m].push_back(b);
  endtask

  // Slave-side NONSEQ addresses in grant order
  task automatic expectOrder(input ahbMatrixPkg::addr_t a);
    orderQ.push_back(a);
  endtask

  function automatic int openBeats();
    int n;
    n = 0;
    for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
      n += expQ[m].size();
    end
    return n;
  endfunction

  ////////////////////
  // Master side
  ////////////////////

  task automatic checkCompletion(input int m);
    expBeat_t b;
    if (expQ[m].size() == 0) begin
      $display("Master %0d finished a transfer that was never issued", m);
      errorCount++;
    end else begin
      b = expQ[m].pop_front();
      checkedCount++;
      if (masterRsp[m].resp !== b.resp) begin
        $display("ERROR masterRsp[%0d].resp got %h expected %h", m, masterRsp[m].resp, b.resp);
        errorCount++;
      end else if (!b.write && !b.resp && (masterRsp[m].rdata !== b.data)) begin
        $display("ERROR masterRsp[%0d].rdata got %h expected %h", m, masterRsp[m].rdata,
                 b.data);
        errorCount++;
      end
    end
  endtask

  ////////////////////
  // Slave side
  ////////////////////

  task automatic checkSlaveAddr(input int s);
    ahbMatrixPkg::addr_t a;
    ahbMatrixPkg::addr_t want;
    a = slaveReq[s].addr;
    // Unmapped accesses never reach a slave
    if ((a & ahbMatrixPkg::slaveMask[s]) != ahbMatrixPkg::slaveBase[s]) begin
      $display("ERROR slaveReq[%0d].addr got %h expected window %h", s, a,
               ahbMatrixPkg::slaveBase[s]);
      errorCount++;
    end
    if (burstLeft[s] > 0) begin
      // Burst beats stay contiguous and from one master
      if ((slaveReq[s].trans != ahbMatrixPkg::transSeq) || (a != nextAddr[s])) begin
        $display("ERROR slaveReq[%0d].addr got %h expected %h", s, a, nextAddr[s]);
        errorCount++;
      end
      burstLeft[s]--;
    end else if ((slaveReq[s].trans == ahbMatrixPkg::transNonseq) && (orderQ.size() > 0)) begin
      want = orderQ.pop_front();
      if (a !== want) begin
        $display("ERROR slaveReq[%0d].addr got %h expected %h", s, a, want);
        errorCount++;
      end
    end
    // INCR4 start
    if ((slaveReq[s].trans == ahbMatrixPkg::transNonseq) && (slaveReq[s].burst == 3'b011)) begin
      burstLeft[s] = 3;
    end
    nextAddr[s] = a + 4;
  endtask

  always @(posedge HCLK) begin
    if (reset) begin
      pending = '0;
      for (int s = 0; s < ahbMatrixPkg::numSlaves; s++) begin
        burstLeft[s] = 0;
      end
    end else begin
      for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
        if (pending[m] && masterRsp[m].ready) begin
          checkCompletion(m);
        end
        // Address phase taken while HREADY is high
        if (masterRsp[m].ready) begin
          pending[m] = masterReq[m].sel && masterReq[m].trans[1];
        end
      end
      for (int s = 0; s < ahbMatrixPkg::numSlaves; s++) begin
        // A slave alone on its layer takes its own HREADYOUT as HREADY
        if (slaveReady[s] !== slaveRsp[s].ready) begin
          $display("ERROR slaveReady[%0d] got %h expected %h", s, slaveReady[s],
                   slaveRsp[s].ready);
          errorCount++;
        end
        if (slaveRsp[s].ready && slaveReq[s].sel && slaveReq[s].trans[1]) begin
          checkSlaveAddr(s);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/ahbMatrixTb.sv
// AHB matrix testbench
`timescale 1ns/1ps
`default_nettype none

module ahbMatrixTb;

  // One trace line
  typedef struct packed {
    logic [1:0]          master;
    logic [7:0]          group;
    logic                write;
    ahbMatrixPkg::addr_t addr;
    logic [2:0]          size;
    logic [3:0]          len;
    ahbMatrixPkg::data_t data;
    logic                resp;
  } traceLine_t;

  logic                                                 HCLK;
  logic                                                 reset;
  ahbMatrixPkg::prio_t [ahbMatrixPkg::numMasters-1:0]   masterPriority;
  ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numMasters-1:0] masterReq;
  ahbMatrixPkg::masterMask_t                            masterReady;
  ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numMasters-1:0] masterRsp;
  ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numSlaves-1:0]  slaveReq;
  ahbMatrixPkg::slaveMask_t                             slaveReady;
  ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numSlaves-1:0]  slaveRsp;

  traceLine_t trace[$];
  int         lastGroup = 0;
  int         cycleLimit = 0;
  int         cycles = 0;

  ahbMatrix dut0 (
    .HCLK          (HCLK),
    .reset         (reset),
    .masterPriority(masterPriority),
    .masterReq     (masterReq),
    .masterReady   (masterReady),
    .masterRsp     (masterRsp),
    .slaveReq      (slaveReq),
    .slaveReady    (slaveReady),
    .slaveRsp      (slaveRsp)
  );

  ahbMemSlave mem0 (.HCLK(HCLK), .reset(reset), .req(slaveReq[0]), .ready(slaveReady[0]),
                    .rsp(slaveRsp[0]));
  ahbMemSlave mem1 (.HCLK(HCLK), .reset(reset), .req(slaveReq[1]), .ready(slaveReady[1]),
                    .rsp(slaveRsp[1]));

  ahbMatrixChecker checker0 (
    .HCLK      (HCLK),
    .reset     (reset),
    .masterReq (masterReq),
    .masterRsp (masterRsp),
    .slaveReq  (slaveReq),
    .slaveReady(slaveReady),
    .slaveRsp  (slaveRsp)
  );

  // Masters see their own HREADYOUT as HREADY
  always_comb begin
    for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
      masterReady[m] = masterRsp[m].ready;
    end
  end

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  ////////////////////
  // Trace handling
  ////////////////////

  task automatic readTrace(output bit opened);
    int          fh;
    int          n;
    int          fm, fg, fw, fs, fl, fr;
    logic [31:0] fa, fd;
    string       text;
    traceLine_t  t;
    fh = $fopen("verif/ahbMatrixTrace.txt", "r");
    opened = (fh != 0);
    if (opened) begin
      while (!$feof(fh)) begin
        text = "";
        n = $fgets(text, fh);
        // Skip comment lines
        if ((n > 0) && (text.len() > 1) && (text.substr(0, 0) != "#")) begin
          n = $sscanf(text, "%d %d %d %h %d %d %h %d", fm, fg, fw, fa, fs, fl, fd, fr);
          if (n == 8) begin
            t = '{master: fm, group: fg, write: fw, addr: fa, size: fs, len: fl,
                  data: fd, resp: fr};
            trace.push_back(t);
            if (fg > lastGroup) begin
              lastGroup = fg;
            end
          end
        end
      end
      $fclose(fh);
    end
  endtask

  function automatic int slaveOf(input ahbMatrixPkg::addr_t a);
    int found;
    found = -1;
    for (int s = 0; s < ahbMatrixPkg::numSlaves; s++) begin
      if ((a & ahbMatrixPkg::slaveMask[s]) == ahbMatrixPkg::slaveBase[s]) begin
        found = s;
      end
    end
    return found;
  endfunction

  // One single per master to one slave, so order follows priority then index
  task automatic planOrder(input int g);
    traceLine_t                grp[$];
    ahbMatrixPkg::masterMask_t seen;
    bit                        ok;
    int                        slv;
    foreach (trace[i]) begin
      if (trace[i].group == g) begin
        grp.push_back(trace[i]);
      end
    end
    ok   = (grp.size() == ahbMatrixPkg::numMasters);
    seen = '0;
    slv  = (grp.size() > 0) ? slaveOf(grp[0].addr) : -1;
    foreach (grp[i]) begin
      if ((grp[i].len != 1) || (slv < 0) || (slaveOf(grp[i].addr) != slv) ||
          seen[grp[i].master]) begin
        ok = 1'b0;
      end
      seen[grp[i].master] = 1'b1;
    end
    if (ok) begin
      for (int p = (1 << ahbMatrixPkg::prioWidth) - 1; p >= 0; p--) begin
        for (int m = 0; m < ahbMatrixPkg::numMasters; m++) begin
          foreach (grp[i]) begin
            if ((grp[i].master == m) && (masterPriority[m] == p)) begin
              checker0.expectOrder(grp[i].addr);
            end
          end
        end
      end
    end
  endtask

  ////////////////////
  // Master driver
  ////////////////////

  // Pipelined AHB-Lite master for one group of lines
  task automatic issueGroup(input int m, input int g);
    ahbMatrixPkg::ahbReq_t beats[$];
    logic                  expResp[$];
    ahbMatrixPkg::ahbReq_t r;
    ahbMatrixPkg::data_t   liveWdata;
    int                    next;
    bit                    addrLive;
    bit                    dataLive;
    foreach (trace[i]) begin
      if ((trace[i].master == m) && (trace[i].group == g)) begin
        for (int b = 0; b < trace[i].len; b++) begin
          r.sel   = 1'b1;
          r.addr  = trace[i].addr + 4 * b;
          r.write = trace[i].write;
          r.size  = trace[i].size;
          r.burst = (trace[i].len == 4) ? 3'b011 : 3'b000;
          r.trans = (b == 0) ? ahbMatrixPkg::transNonseq : ahbMatrixPkg::transSeq;
          r.wdata = trace[i].data + b;
          beats.push_back(r);
          expResp.push_back(trace[i].resp);
        end
      end
    end
    next      = 0;
    addrLive  = (beats.size() > 0);
    dataLive  = 1'b0;
    liveWdata = '0;
    @(posedge HCLK);
    if (addrLive) begin
      r       = beats[0];
      r.wdata = liveWdata;
      masterReq[m] <= r;
    end
    while (addrLive || dataLive) begin
      @(posedge HCLK);
      if (masterRsp[m].ready) begin
        dataLive = addrLive;
        if (addrLive) begin
          // Address phase taken so its data phase starts
          liveWdata = beats[next].wdata;
          checker0.expectBeat(m, beats[next].write, beats[next].wdata, expResp[next]);
          next++;
        end
        if (next < beats.size()) begin
          r = beats[next];
        end else begin
          r        = '0;
          addrLive = 1'b0;
        end
        r.wdata = liveWdata;
        masterReq[m] <= r;
      end
    end
  endtask

  task automatic finishRun();
    int checkErr;
    int assertErr;
    int openCount;
    checkErr  = checker0.errorCount;
    assertErr = dut0.props0.failCount;
    openCount = checker0.openBeats();
    $display("Summary: %0d check errors, %0d assertion errors, %0d open beats, %0d checked",
             checkErr, assertErr, openCount, checker0.checkedCount);
    if ((checkErr == 0) && (assertErr == 0) && (openCount == 0)) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    bit opened;
    void'($urandom(32'h0989_5145));
    reset          = 1'b1;
    masterPriority = {2'd1, 2'd3, 2'd1};
    masterReq      = '0;
    readTrace(opened);
    if (!opened) begin
      $display("Trace file verif/ahbMatrixTrace.txt could not be opened");
      $display("** FAIL **");
      $finish;
    end else begin
      cycleLimit = trace.size() * 40;
      repeat (16) @(posedge HCLK);
      reset <= 1'b0;
      // Groups start together once the previous one is done
      for (int g = 0; g <= lastGroup; g++) begin
        planOrder(g);
        fork
          issueGroup(0, g);
          issueGroup(1, g);
          issueGroup(2, g);
        join
      end
      repeat (4) @(posedge HCLK);
      finishRun();
    end
  end

  // Watchdog
  initial begin
    wait (cycleLimit > 0);
    forever begin
      @(posedge HCLK);
      cycles++;
      if (cycles >= cycleLimit) begin
        $display("Timeout: transfers still open after %0d cycles", cycles);
        $display("** FAIL **");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/ahbMatrixTrace.txt
# master group write addr(hex) size len data(hex) resp
# data is write data or expected read data, beat i uses addr+4*i and data+i
0 0 1 00000010 2 1 a0a00010 0
0 0 1 00010010 2 1 a1a10010 0
0 0 0 00000010 2 1 a0a00010 0
0 0 0 00010010 2 1 a1a10010 0
1 0 1 00010020 2 1 b1b10020 0
1 0 1 00000020 2 1 b0b00020 0
1 0 0 00010020 2 1 b1b10020 0
1 0 0 00000020 2 1 b0b00020 0
2 0 1 00000030 2 1 c0c00030 0
2 0 1 00010030 2 1 c1c10030 0
2 0 0 00000030 2 1 c0c00030 0
2 0 0 00010030 2 1 c1c10030 0
2 1 0 00020000 2 1 00000000 1
2 1 0 00000010 2 1 a0a00010 0
0 1 1 80000000 2 1 deadbeef 1
0 2 1 00000300 2 1 d0000300 0
1 2 1 00000304 2 1 d1000304 0
2 2 1 00000308 2 1 d2000308 0
0 3 1 00010100 2 4 e0000000 0
2 3 0 00010010 2 1 a1a10010 0
1 3 1 00000040 2 1 f0000040 0
1 3 1 00010200 2 1 f1010200 0
0 4 0 00010100 2 4 e0000000 0
1 4 0 00010200 2 1 f1010200 0
2 4 0 00000308 2 1 d2000308 0
2 4 0 00000304 2 1 d1000304 0

//--- verif/ahbMatrix_properties.sv
// AHB matrix protocol assertions
`timescale 1ns/1ps
`default_nettype none

module ahbMatrixProperties (
  input logic                                                     HCLK,
  input logic                                                     reset,
  input ahbMatrixPkg::ahbReq_t [ahbMatrixPkg::numSlaves-1:0]      slaveReq,
  input ahbMatrixPkg::ahbRsp_t [ahbMatrixPkg::numMasters-1:0]     masterRsp,
  input ahbMatrixPkg::masterMask_t [ahbMatrixPkg::numSlaves-1:0]  slaveGrant
);

  // Number of failed assertions
  int failCount = 0;

  genvar s;
  genvar m;

  for (s = 0; s < ahbMatrixPkg::numSlaves; s++) begin : genSlaveRules
    idleWhenDeselected: assert property (@(posedge HCLK) disable iff (reset)
      !slaveReq[s].sel |-> (slaveReq[s].trans == ahbMatrixPkg::transIdle))
      else begin
        $error("Slave %0d sees a transfer without HSEL", s);
        failCount++;
      end
    // At most one master owns a slave
    grantOneHot: assert property (@(posedge HCLK) disable iff (reset)
      $onehot0(slaveGrant[s]))
      else begin
        $error("Slave %0d grant mask is not one-hot", s);
        failCount++;
      end
  end

  // ERROR is low-ready then high-ready
  for (m = 0; m < ahbMatrixPkg::numMasters; m++) begin : genMasterRules
    errorTwoCycles: assert property (@(posedge HCLK) disable iff (reset)
      $rose(masterRsp[m].resp) |-> !masterRsp[m].ready ##1
                                   (masterRsp[m].resp && masterRsp[m].ready))
      else begin
        $error("Master %0d ERROR response is not two cycles", m);
        failCount++;
      end
  end

endmodule

bind ahbMatrix ahbMatrixProperties props0 (
  .HCLK      (HCLK),
  .reset     (reset),
  .slaveReq  (slaveReq),
  .masterRsp (masterRsp),
  .slaveGrant(fromSlvGrant)
);

`default_nettype wire

//--- verif/ahbMemSlave.sv
// Behavioral AHB-Lite memory
`timescale 1ns/1ps
`default_nettype none

module ahbMemSlave (
  input  logic                  HCLK,
  input  logic                  reset,
  input  ahbMatrixPkg::ahbReq_t req,
  input  logic                  ready,
  output ahbMatrixPkg::ahbRsp_t rsp
);

  // 4 KiB window, word addressed
  ahbMatrixPkg::data_t mem [1024];
  logic                active;
  logic                phaseWrite;
  logic [9:0]          phaseAddr;
  logic [1:0]          waitLeft;
  logic                readyOut;

  always_ff @(posedge HCLK) begin
    int unsigned draw;
    if (reset) begin
      active     <= 1'b0;
      phaseWrite <= 1'b0;
      phaseAddr  <= '0;
      waitLeft   <= '0;
      readyOut   <= 1'b1;
      // Fill depends on every address bit of the window
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= 32'h5A00_0000 | (i << 2);
      end
    end else if (ready) begin
      // Data phase ends here, write lands now
      if (active && phaseWrite) begin
        mem[phaseAddr] <= req.wdata;
      end
      if (req.sel && req.trans[1]) begin
        draw       = $urandom % 3;
        active     <= 1'b1;
        phaseWrite <= req.write;
        phaseAddr  <= req.addr[11:2];
        waitLeft   <= draw[1:0];
        readyOut   <= (draw == 0);
      end else begin
        active   <= 1'b0;
        readyOut <= 1'b1;
      end
    end else begin
      // Count down the wait states
      if (waitLeft == 2'd1) begin
        readyOut <= 1'b1;
      end
      waitLeft <= waitLeft - 2'd1;
    end
  end

  always_comb begin
    rsp.rdata = (active && !phaseWrite) ? mem[phaseAddr] : '0;
    rsp.ready = readyOut;
    rsp.resp  = 1'b0;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/ahbMatrixPkg.sv
src/ahbMasterPort.sv
src/ahbSlavePort.sv
src/ahbMatrix.sv
verif/ahbMemSlave.sv
verif/ahbMatrixChecker.sv
verif/ahbMatrix_properties.sv
verif/ahbMatrixTb.sv
